// File: common/mem_sys_pkg.sv
// --------------------
// Memory system shared definitions
// Widths, address decode and refill request kinds
// --------------------
package mem_sys_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int line_w = 128;

  // Words per line, byte offset bits per line
  localparam int line_words = line_w / data_w;
  localparam int off_w      = $clog2(line_w / 8);

  // --------------------
  // Address views
  // --------------------

  // Index field sized for a 16-line cache
  // offset holds the word select above two byte bits
  typedef union packed {
    logic [addr_w-1:0] raw;
    struct packed {
      logic [addr_w-off_w-5:0] tag;
      logic [3:0]              index;
      logic [off_w-1:0]        offset;
    } f;
  } addr_u;

  // One cache line as four words
  typedef logic [line_words-1:0][data_w-1:0] line_t;

  // --------------------
  // Refill request kinds
  // --------------------

  typedef enum logic {
    req_read  = 1'b0,
    req_write = 1'b1
  } req_kind_e;

endpackage

// File: common/refill_if.sv
// --------------------
// Refill port between a cache and the refill arbiter
// --------------------
interface refill_if;

  import mem_sys_pkg::*;

  // Request strobe and payload, cache side
  logic              req_val;
  req_kind_e         req_kind;
  logic [addr_w-1:0] req_addr;
  logic [data_w-1:0] req_wdata;

  // Response strobe and line, arbiter side
  logic              resp_val;
  line_t             resp_line;

  modport cache (
    output req_val, req_kind, req_addr, req_wdata,
    input  resp_val, resp_line
  );

  modport arb (
    input  req_val, req_kind, req_addr, req_wdata,
    output resp_val, resp_line
  );

endinterface

// File: cache/icache.sv
// --------------------
// Instruction cache
// Direct-mapped and read-only, refills whole lines
// --------------------
module icache #(
  parameter int p_nbytes = 256
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           req_val,
  input  mem_sys_pkg::addr_u             req_addr,
  output logic                           resp_val,
  output logic [mem_sys_pkg::data_w-1:0] resp_data,
  refill_if.cache                        refill
);

  import mem_sys_pkg::*;

  localparam int c_nlines = p_nbytes * 8 / line_w;
  localparam int c_idx_w  = $clog2(c_nlines);
  localparam int c_tag_w  = addr_w - off_w - c_idx_w;

  // Tag is everything above the index bits this cache uses
  function automatic logic [c_tag_w-1:0] tag_of(addr_u a);
    return c_tag_w'({a.f.tag, a.f.index} >> c_idx_w);
  endfunction

  logic [c_tag_w-1:0]  tag_mem  [c_nlines];
  line_t               line_mem [c_nlines];
  logic [c_nlines-1:0] valid;

  logic               busy;
  addr_u              addr_q;
  logic [c_idx_w-1:0] idx;
  logic [c_idx_w-1:0] idx_q;
  logic               hit;

  assign idx   = req_addr.f.index[c_idx_w-1:0];
  assign idx_q = addr_q.f.index[c_idx_w-1:0];
  assign hit   = valid[idx] && (tag_mem[idx] == tag_of(req_addr));

  // Only line reads leave this cache
  assign refill.req_kind  = req_read;
  assign refill.req_wdata = '0;

  // --------------------
  // Control
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy           <= 1'b0;
      valid          <= '0;
      resp_val       <= 1'b0;
      refill.req_val <= 1'b0;
    end else begin
      resp_val       <= 1'b0;
      refill.req_val <= 1'b0;
      if (!busy && req_val) begin
        if (hit) begin
          resp_val <= 1'b1;
        end else begin
          busy           <= 1'b1;
          refill.req_val <= 1'b1;
        end
      end else if (busy && refill.resp_val) begin
        busy         <= 1'b0;
        valid[idx_q] <= 1'b1;
        resp_val     <= 1'b1;
      end
    end
  end

  // --------------------
  // Arrays and payload
  // --------------------

  always_ff @(posedge clk) begin
    if (!busy && req_val) begin
      addr_q          <= req_addr;
      resp_data       <= line_mem[idx][req_addr.f.offset[off_w-1:2]];
      refill.req_addr <= {req_addr.f.tag, req_addr.f.index, off_w'(0)};
    end
    // Fill the line and forward the missed word
    if (busy && refill.resp_val) begin
      line_mem[idx_q] <= refill.resp_line;
      tag_mem[idx_q]  <= tag_of(addr_q);
      resp_data       <= refill.resp_line[addr_q.f.offset[off_w-1:2]];
    end
  end

endmodule

// File: cache/dcache.sv
// --------------------
// Data cache
// Direct-mapped, write-through, no allocate on write miss
// --------------------
module dcache #(
  parameter int p_nbytes = 256
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           req_val,
  input  logic                           req_wen,
  input  mem_sys_pkg::addr_u             req_addr,
  input  logic [mem_sys_pkg::data_w-1:0] req_wdata,
  output logic                           resp_val,
  output logic [mem_sys_pkg::data_w-1:0] resp_data,
  refill_if.cache                        refill
);

  import mem_sys_pkg::*;

  localparam int c_nlines = p_nbytes * 8 / line_w;
  localparam int c_idx_w  = $clog2(c_nlines);
  localparam int c_tag_w  = addr_w - off_w - c_idx_w;

  function automatic logic [c_tag_w-1:0] tag_of(addr_u a);
    return c_tag_w'({a.f.tag, a.f.index} >> c_idx_w);
  endfunction

  logic [c_tag_w-1:0]  tag_mem  [c_nlines];
  line_t               line_mem [c_nlines];
  logic [c_nlines-1:0] valid;

  logic               busy;
  addr_u              addr_q;
  logic [c_idx_w-1:0] idx;
  logic [c_idx_w-1:0] idx_q;
  logic [1:0]         wsel;
  logic               hit;
  logic               start;
  logic               done;

  assign idx   = req_addr.f.index[c_idx_w-1:0];
  assign idx_q = addr_q.f.index[c_idx_w-1:0];
  assign wsel  = req_addr.f.offset[off_w-1:2];
  assign hit   = valid[idx] && (tag_mem[idx] == tag_of(req_addr));
  assign start = !busy && req_val;
  assign done  = busy && refill.resp_val;

  // --------------------
  // Control
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy            <= 1'b0;
      valid           <= '0;
      resp_val        <= 1'b0;
      refill.req_val  <= 1'b0;
      refill.req_kind <= req_read;
    end else begin
      resp_val       <= 1'b0;
      refill.req_val <= 1'b0;
      if (start) begin
        // Read hits answer locally, everything else goes to memory
        if (!req_wen && hit) begin
          resp_val <= 1'b1;
        end else begin
          busy            <= 1'b1;
          refill.req_val  <= 1'b1;
          refill.req_kind <= req_wen ? req_write : req_read;
        end
      end else if (done) begin
        busy     <= 1'b0;
        resp_val <= 1'b1;
        if (refill.req_kind == req_read) begin
          valid[idx_q] <= 1'b1;
        end
      end
    end
  end

  // --------------------
  // Arrays and payload
  // --------------------

  always_ff @(posedge clk) begin
    if (start) begin
      addr_q    <= req_addr;
      resp_data <= line_mem[idx][wsel];
      if (req_wen) begin
        refill.req_addr  <= req_addr.raw;
        refill.req_wdata <= req_wdata;
        // Keep a resident line in step with memory
        if (hit) begin
          line_mem[idx][wsel] <= req_wdata;
        end
      end else begin
        refill.req_addr  <= {req_addr.f.tag, req_addr.f.index, off_w'(0)};
        refill.req_wdata <= '0;
      end
    end
    if (done) begin
      if (refill.req_kind == req_read) begin
        line_mem[idx_q] <= refill.resp_line;
        tag_mem[idx_q]  <= tag_of(addr_q);
        resp_data       <= refill.resp_line[addr_q.f.offset[off_w-1:2]];
      end else begin
        // write ack carries no data
        resp_data <= '0;
      end
    end
  end

endmodule

// File: logic/refill_arbiter.sv
// --------------------
// Refill arbiter
// Shares one memory port between both caches
// --------------------
module refill_arbiter (
  input  logic                           clk,
  input  logic                           rst_n,
  refill_if.arb                          irefill,
  refill_if.arb                          drefill,
  output logic                           mem_req_val,
  output logic                           mem_req_wen,
  output logic [mem_sys_pkg::addr_w-1:0] mem_req_addr,
  output logic [mem_sys_pkg::data_w-1:0] mem_req_wdata,
  input  logic                           mem_resp_val,
  input  mem_sys_pkg::line_t             mem_resp_line
);

  import mem_sys_pkg::*;

  // Pending request per side
  logic              ipend;
  logic              dpend;
  req_kind_e         ikind;
  req_kind_e         dkind;
  logic [addr_w-1:0] iaddr;
  logic [addr_w-1:0] daddr;
  logic [data_w-1:0] iwdata;
  logic [data_w-1:0] dwdata;

  // Single outstanding memory request and its owner
  logic outst;
  logic owner_d;

  logic grant;
  logic grant_d;

  // Instruction side wins a tie
  assign grant   = (ipend || dpend) && !outst;
  assign grant_d = !ipend;

  assign mem_req_val   = grant;
  assign mem_req_wen   = grant_d ? (dkind == req_write) : (ikind == req_write);
  assign mem_req_addr  = grant_d ? daddr : iaddr;
  assign mem_req_wdata = grant_d ? dwdata : iwdata;

  // Steer the response to whoever owns the memory request
  assign irefill.resp_val  = mem_resp_val && outst && !owner_d;
  assign drefill.resp_val  = mem_resp_val && outst && owner_d;
  assign irefill.resp_line = mem_resp_line;
  assign drefill.resp_line = mem_resp_line;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ipend   <= 1'b0;
      dpend   <= 1'b0;
      outst   <= 1'b0;
      owner_d <= 1'b0;
    end else begin
      if (irefill.req_val) begin
        ipend <= 1'b1;
      end else if (grant && !grant_d) begin
        ipend <= 1'b0;
      end
      if (drefill.req_val) begin
        dpend <= 1'b1;
      end else if (grant && grant_d) begin
        dpend <= 1'b0;
      end
      if (grant) begin
        outst   <= 1'b1;
        owner_d <= grant_d;
      end else if (mem_resp_val) begin
        outst <= 1'b0;
      end
    end
  end

  // Request payload capture
  always_ff @(posedge clk) begin
    if (irefill.req_val) begin
      ikind  <= irefill.req_kind;
      iaddr  <= irefill.req_addr;
      iwdata <= irefill.req_wdata;
    end
    if (drefill.req_val) begin
      dkind  <= drefill.req_kind;
      daddr  <= drefill.req_addr;
      dwdata <= drefill.req_wdata;
    end
  end

endmodule

// File: logic/mem_sys.sv
// --------------------
// Memory system
// Instruction and data caches over one memory port
// --------------------
module mem_sys #(
  parameter int p_icache_nbytes = 256,
  parameter int p_dcache_nbytes = 256
) (
  input  logic                           clk,
  input  logic                           rst_n,

  // Instruction side
  input  logic                           imem_req_val,
  input  logic [mem_sys_pkg::addr_w-1:0] imem_req_addr,
  output logic                           imem_resp_val,
  output logic [mem_sys_pkg::data_w-1:0] imem_resp_data,

  // Data side
  input  logic                           dmem_req_val,
  input  logic                           dmem_req_wen,
  input  logic [mem_sys_pkg::addr_w-1:0] dmem_req_addr,
  input  logic [mem_sys_pkg::data_w-1:0] dmem_req_wdata,
  output logic                           dmem_resp_val,
  output logic [mem_sys_pkg::data_w-1:0] dmem_resp_data,

  // Memory side
  output logic                           mem_req_val,
  output logic                           mem_req_wen,
  output logic [mem_sys_pkg::addr_w-1:0] mem_req_addr,
  output logic [mem_sys_pkg::data_w-1:0] mem_req_wdata,
  input  logic                           mem_resp_val,
  input  logic [mem_sys_pkg::line_w-1:0] mem_resp_line
);

  // Refill ports
  refill_if irefill ();
  refill_if drefill ();

  icache #(
    .p_nbytes (p_icache_nbytes)
  ) i_icache (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_val   (imem_req_val),
    .req_addr  (imem_req_addr),
    .resp_val  (imem_resp_val),
    .resp_data (imem_resp_data),
    .refill    (irefill.cache)
  );

  dcache #(
    .p_nbytes (p_dcache_nbytes)
  ) i_dcache (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_val   (dmem_req_val),
    .req_wen   (dmem_req_wen),
    .req_addr  (dmem_req_addr),
    .req_wdata (dmem_req_wdata),
    .resp_val  (dmem_resp_val),
    .resp_data (dmem_resp_data),
    .refill    (drefill.cache)
  );

  refill_arbiter i_refill_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .irefill       (irefill.arb),
    .drefill       (drefill.arb),
    .mem_req_val   (mem_req_val),
    .mem_req_wen   (mem_req_wen),
    .mem_req_addr  (mem_req_addr),
    .mem_req_wdata (mem_req_wdata),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_line (mem_resp_line)
  );

endmodule

// File: bench/mem_sys_sva.sv
// --------------------
// Refill arbiter assertions
// One outstanding request, owned responses, quiet after reset
// --------------------
module mem_sys_sva (
  input logic clk,
  input logic rst_n,
  input logic ireq_val,
  input logic iresp_val,
  input logic dreq_val,
  input logic dresp_val,
  input logic mem_req_val,
  input logic mem_resp_val
);

  timeunit 1ns;
  timeprecision 1ps;

  logic iflight;
  logic dflight;
  logic outst;

  // Track requests in flight per side and at memory
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      iflight <= 1'b0;
      dflight <= 1'b0;
      outst   <= 1'b0;
    end else begin
      if (ireq_val) begin
        iflight <= 1'b1;
      end else if (iresp_val) begin
        iflight <= 1'b0;
      end
      if (dreq_val) begin
        dflight <= 1'b1;
      end else if (dresp_val) begin
        dflight <= 1'b0;
      end
      if (mem_req_val) begin
        outst <= 1'b1;
      end else if (mem_resp_val) begin
        outst <= 1'b0;
      end
    end
  end

  a_single_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    outst |-> !mem_req_val)
    else $error("memory request issued while another is outstanding");

  a_iresp_owned: assert property (@(posedge clk) disable iff (!rst_n)
    iresp_val |-> iflight)
    else $error("instruction refill response with no request in flight");

  a_dresp_owned: assert property (@(posedge clk) disable iff (!rst_n)
    dresp_val |-> dflight)
    else $error("data refill response with no request in flight");

  a_quiet_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !(mem_req_val || iresp_val || dresp_val))
    else $error("strobe active in the first cycle after reset");

endmodule

bind refill_arbiter mem_sys_sva i_mem_sys_sva (
  .clk          (clk),
  .rst_n        (rst_n),
  .ireq_val     (irefill.req_val),
  .iresp_val    (irefill.resp_val),
  .dreq_val     (drefill.req_val),
  .dresp_val    (drefill.resp_val),
  .mem_req_val  (mem_req_val),
  .mem_resp_val (mem_resp_val)
);

// File: bench/mem_sys_tb.sv
// --------------------
// Memory system testbench
// Random instruction and data traffic checked against memory and tag models
// --------------------
module mem_sys_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_per_side     = 1000;
  localparam int timeout_cycles = 200;
  localparam int n_words        = 512;
  localparam int n_lines        = 16;

  logic         clk;
  logic         rst_n;
  logic         imem_req_val;
  logic [31:0]  imem_req_addr;
  logic         imem_resp_val;
  logic [31:0]  imem_resp_data;
  logic         dmem_req_val;
  logic         dmem_req_wen;
  logic [31:0]  dmem_req_addr;
  logic [31:0]  dmem_req_wdata;
  logic         dmem_resp_val;
  logic [31:0]  dmem_resp_data;
  logic         mem_req_val;
  logic         mem_req_wen;
  logic [31:0]  mem_req_addr;
  logic [31:0]  mem_req_wdata;
  logic         mem_resp_val;
  logic [127:0] mem_resp_line;

  integer seed = 32'h2b2fb587;

  // Memory model contents and reference contents
  logic [31:0] mem     [n_words];
  logic [31:0] ref_mem [n_words];

  // Memory requests seen per side
  logic [31:0] ird_q [$];
  logic [31:0] drd_q [$];
  logic [63:0] dwr_q [$];

  // Tag model, 16 lines of 16 bytes per cache
  logic        itag_valid [n_lines];
  logic [23:0] itag       [n_lines];
  logic        dtag_valid [n_lines];
  logic [23:0] dtag       [n_lines];

  mem_sys #(
    .p_icache_nbytes (256),
    .p_dcache_nbytes (256)
  ) i_mem_sys (
    .clk            (clk),
    .rst_n          (rst_n),
    .imem_req_val   (imem_req_val),
    .imem_req_addr  (imem_req_addr),
    .imem_resp_val  (imem_resp_val),
    .imem_resp_data (imem_resp_data),
    .dmem_req_val   (dmem_req_val),
    .dmem_req_wen   (dmem_req_wen),
    .dmem_req_addr  (dmem_req_addr),
    .dmem_req_wdata (dmem_req_wdata),
    .dmem_resp_val  (dmem_resp_val),
    .dmem_resp_data (dmem_resp_data),
    .mem_req_val    (mem_req_val),
    .mem_req_wen    (mem_req_wen),
    .mem_req_addr   (mem_req_addr),
    .mem_req_wdata  (mem_req_wdata),
    .mem_resp_val   (mem_resp_val),
    .mem_resp_line  (mem_resp_line)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // --------------------
  // Helpers
  // --------------------

  function automatic logic [31:0] init_word(input logic [31:0] a);
    return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a0f0f;
  endfunction

  task automatic abort_run;
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    abort_run();
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: no %s within %0d cycles", what, timeout_cycles);
    abort_run();
  endtask

  // Hit answers next cycle without memory traffic, miss reads one aligned line
  task automatic check_refill(input logic hit, input int waited, input logic [31:0] a,
                              input int nreq, input logic [31:0] first);
    if (hit) begin
      assert (waited == 1)
        else report_mismatch($sformatf("hit at %h answered after %0d cycles", a, waited));
      assert (nreq == 0)
        else report_mismatch($sformatf("hit at %h reached memory", a));
    end else begin
      assert (nreq == 1 && first == {a[31:4], 4'h0})
        else report_mismatch($sformatf("miss at %h gave %0d line reads", a, nreq));
    end
  endtask

  // --------------------
  // Request streams
  // --------------------

  task automatic run_ifetch(input int count);
    logic [31:0] a;
    logic        hit;
    int          idx;
    int          waited;
    for (int n = 0; n < count; n++) begin
      a   = ($unsigned($random(seed)) % 256) * 4;
      idx = a[7:4];
      hit = itag_valid[idx] && (itag[idx] == a[31:8]);
      imem_req_val  <= 1'b1;
      imem_req_addr <= a;
      @(posedge clk);
      imem_req_val <= 1'b0;
      waited = 0;
      do begin
        @(posedge clk);
        waited++;
        if (waited > timeout_cycles) report_timeout("instruction response");
      end while (!imem_resp_val);
      assert (imem_resp_data == ref_mem[a[10:2]])
        else report_mismatch($sformatf("ifetch %h got %h expected %h", a, imem_resp_data,
                                       ref_mem[a[10:2]]));
      check_refill(hit, waited, a, ird_q.size(), (ird_q.size() > 0) ? ird_q[0] : '0);
      ird_q.delete();
      itag_valid[idx] = 1'b1;
      itag[idx]       = a[31:8];
    end
  endtask

  task automatic run_data(input int count);
    logic [31:0] a;
    logic [31:0] wd;
    logic        wen;
    logic        hit;
    int          idx;
    int          waited;
    for (int n = 0; n < count; n++) begin
      a   = 32'h400 + ($unsigned($random(seed)) % 256) * 4;
      wen = ($unsigned($random(seed)) % 3) == 0;
      wd  = $random(seed);
      idx = a[7:4];
      hit = dtag_valid[idx] && (dtag[idx] == a[31:8]);
      dmem_req_val   <= 1'b1;
      dmem_req_wen   <= wen;
      dmem_req_addr  <= a;
      dmem_req_wdata <= wd;
      @(posedge clk);
      dmem_req_val <= 1'b0;
      waited = 0;
      do begin
        @(posedge clk);
        waited++;
        if (waited > timeout_cycles) report_timeout("data response");
      end while (!dmem_resp_val);
      if (wen) begin
        ref_mem[a[10:2]] = wd;
        assert (dmem_resp_data == '0)
          else report_mismatch($sformatf("write ack %h carries %h", a, dmem_resp_data));
        assert (dwr_q.size() == 1 && dwr_q[0] == {a, wd})
          else report_mismatch($sformatf("write %h of %h not seen once at memory", a, wd));
        dwr_q.delete();
      end else begin
        assert (dmem_resp_data == ref_mem[a[10:2]])
          else report_mismatch($sformatf("load %h got %h expected %h", a, dmem_resp_data,
                                         ref_mem[a[10:2]]));
        check_refill(hit, waited, a, drd_q.size(), (drd_q.size() > 0) ? drd_q[0] : '0);
        drd_q.delete();
        dtag_valid[idx] = 1'b1;
        dtag[idx]       = a[31:8];
      end
    end
  endtask

  // --------------------
  // Memory model
  // --------------------

  initial begin
    int delay;
    int b;
    mem_resp_val  = 1'b0;
    mem_resp_line = '0;
    for (int i = 0; i < n_words; i++) begin
      mem[i] = init_word(i * 4);
    end
    forever begin
      @(posedge clk);
      mem_resp_val <= 1'b0;
      if (rst_n && mem_req_val) begin
        assert (mem_req_addr < 32'h800)
          else report_mismatch($sformatf("memory address %h out of range", mem_req_addr));
        b = mem_req_addr[10:4] * 4;
        if (mem_req_wen) begin
          dwr_q.push_back({mem_req_addr, mem_req_wdata});
          mem[mem_req_addr[10:2]] = mem_req_wdata;
        end else if (mem_req_addr < 32'h400) begin
          ird_q.push_back(mem_req_addr);
        end else begin
          drd_q.push_back(mem_req_addr);
        end
        delay = 1 + $unsigned($random(seed)) % 6;
        repeat (delay - 1) @(posedge clk);
        mem_resp_val  <= 1'b1;
        mem_resp_line <= {mem[b + 3], mem[b + 2], mem[b + 1], mem[b]};
      end
    end
  end

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    rst_n          = 1'b0;
    imem_req_val   = 1'b0;
    imem_req_addr  = '0;
    dmem_req_val   = 1'b0;
    dmem_req_wen   = 1'b0;
    dmem_req_addr  = '0;
    dmem_req_wdata = '0;
    for (int i = 0; i < n_words; i++) begin
      ref_mem[i] = init_word(i * 4);
    end
    for (int i = 0; i < n_lines; i++) begin
      itag_valid[i] = 1'b0;
      dtag_valid[i] = 1'b0;
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    // Both sides run at once and share the memory port
    fork
      run_ifetch(n_per_side);
      run_data(n_per_side);
    join
    assert (ird_q.size() == 0 && drd_q.size() == 0 && dwr_q.size() == 0)
      else report_mismatch("memory requests left with no matching access");
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: mem_sys.f
common/mem_sys_pkg.sv
common/refill_if.sv
cache/icache.sv
cache/dcache.sv
logic/refill_arbiter.sv
logic/mem_sys.sv
bench/mem_sys_sva.sv
bench/mem_sys_tb.sv

// File: Bender.yml
package:
  name: mem_sys

sources:
  - common/mem_sys_pkg.sv
  - common/refill_if.sv
  - cache/icache.sv
  - cache/dcache.sv
  - logic/refill_arbiter.sv
  - logic/mem_sys.sv
  - target: test
    files:
      - bench/mem_sys_sva.sv
      - bench/mem_sys_tb.sv
